//--- dso_consts.svh
`ifndef DSO_CONSTS_SVH
`define DSO_CONSTS_SVH

// record geometry
`define DSO_HORIZONTAL      256
`define DSO_ADDR_WIDTH      8

`define DSO_AXI_ADDR_WIDTH  13

// register map
`define DSO_REG_CTRL        13'h0000
`define DSO_REG_LEVEL       13'h0004
`define DSO_REG_STATUS      13'h0008
`define DSO_REG_TRIG_ADDR   13'h000C
`define DSO_REG_REFRESH     13'h0010

// sample n sits at base + 4*n
`define DSO_WAVE_BASE       13'h1000

`endif

//--- dso_pkg.sv
`default_nettype none

package dso_pkg;

  typedef logic [7:0] sample_t;  // one adc sample

  typedef enum logic {
    EDGE_FALL = 1'b0,
    EDGE_RISE = 1'b1
  } edge_e;

  typedef logic [1:0] bank_ptr_t;  // bit 1 wrap, bit 0 bank

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  typedef enum logic [2:0] {
    REG_CTRL,
    REG_LEVEL,
    REG_STATUS,
    REG_TRIG_ADDR,
    REG_REFRESH,
    REG_WAVE,
    REG_NONE
  } reg_idx_e;

endpackage

`default_nettype wire

//--- dso_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module dso_trigger (
  input  wire logic            ad_clk,
  input  wire logic            rstn,
  input  wire logic            run,
  input  wire logic            sample_en,
  input  wire dso_pkg::sample_t ad_data,
  input  wire dso_pkg::sample_t level,
  input  wire dso_pkg::edge_e  edge_sel,
  output logic                 crossing
);
  import dso_pkg::*;

  sample_t h0, h1, h2, h3;  // h0 newest
  logic    rise_hit, fall_hit;

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      h0 <= '0;
      h1 <= '0;
      h2 <= '0;
      h3 <= '0;
    end else if (!run) begin
      h0 <= '0;
      h1 <= '0;
      h2 <= '0;
      h3 <= '0;
    end else if (sample_en) begin
      h0 <= ad_data;
      h1 <= h0;
      h2 <= h1;
      h3 <= h2;
    end
  end

  // two below, then settle above the level
  assign rise_hit = (h3 < level) && (h2 < level) && (h1 >= level) && (h0 > level);
  assign fall_hit = (h3 > level) && (h2 > level) && (h1 <= level) && (h0 < level);

  assign crossing = (edge_sel == EDGE_RISE) ? rise_hit : fall_hit;

endmodule

`default_nettype wire

//--- dso_sample_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "dso_consts.svh"

module dso_sample_ram (
  input  wire logic                       ad_clk,
  input  wire logic                       wr_en,
  input  wire logic [`DSO_ADDR_WIDTH:0]   wr_addr,
  input  wire dso_pkg::sample_t           wr_data,
  input  wire logic [`DSO_ADDR_WIDTH:0]   rd_addr,
  output dso_pkg::sample_t                rd_data
);
  import dso_pkg::*;

  // msb of the address picks the ping-pong bank
  sample_t mem [2*`DSO_HORIZONTAL];

  always_ff @(posedge ad_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge ad_clk) begin
    rd_data <= mem[rd_addr];  // one cycle latency
  end

endmodule

`default_nettype wire

//--- dso_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "dso_consts.svh"

module dso_capture (
  input  wire logic                        ad_clk,
  input  wire logic                        rstn,
  input  wire logic                        run,
  input  wire dso_pkg::edge_e              edge_sel,
  input  wire dso_pkg::sample_t            level,
  input  wire dso_pkg::sample_t            ad_data,
  input  wire logic                        deci_valid,
  input  wire logic                        refresh_pulse,
  input  wire logic [`DSO_ADDR_WIDTH-1:0]  wave_rd_addr,
  output dso_pkg::sample_t                 wave_rd_data,
  output logic                             wave_ready,
  output logic [`DSO_ADDR_WIDTH-1:0]       wave_trig_addr
);
  import dso_pkg::*;

  bank_ptr_t                  wr_ptr;
  bank_ptr_t                  rd_ptr;
  logic [`DSO_ADDR_WIDTH-1:0] wr_addr;
  logic [`DSO_ADDR_WIDTH:0]   data_cnt;  // writes into current record
  logic                       triggered;
  logic [`DSO_ADDR_WIDTH-1:0] trig_addr [2];

  logic full, empty, wr_en, armed, crossing, trig_hit, rec_done;

  assign full     = (wr_ptr[0] == rd_ptr[0]) && (wr_ptr[1] != rd_ptr[1]);
  assign empty    = (wr_ptr == rd_ptr);
  assign rec_done = (data_cnt == `DSO_HORIZONTAL);
  assign wr_en    = run && deci_valid && !full && !rec_done;
  assign armed    = !triggered && (data_cnt >= `DSO_HORIZONTAL/2 - 1);
  assign trig_hit = wr_en && armed && crossing;

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wr_addr <= '0;
    end else if (!run) begin
      wr_addr <= '0;
    end else if (wr_en) begin
      wr_addr <= wr_addr + 1'b1;  // wraps at record length
    end
  end

  // pre-trigger part saturates until the trigger lands
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      data_cnt <= '0;
    end else if (!run || rec_done) begin
      data_cnt <= '0;
    end else if (wr_en && (data_cnt < `DSO_HORIZONTAL/2 - 1 || triggered || trig_hit)) begin
      data_cnt <= data_cnt + 1'b1;
    end
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      triggered <= 1'b0;
    end else if (!run || rec_done) begin
      triggered <= 1'b0;
    end else if (trig_hit) begin
      triggered <= 1'b1;
    end
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      trig_addr[0] <= '0;
      trig_addr[1] <= '0;
    end else if (!run) begin
      trig_addr[0] <= '0;
      trig_addr[1] <= '0;
    end else if (trig_hit) begin
      trig_addr[wr_ptr[0]] <= wr_addr - 1'b1;  // h0 went in one write ago
    end
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (!run) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (rec_done) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (refresh_pulse && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign wave_ready     = !empty;
  assign wave_trig_addr = trig_addr[rd_ptr[0]];

  dso_trigger u_trigger (
    .ad_clk   (ad_clk),
    .rstn     (rstn),
    .run      (run),
    .sample_en(wr_en),
    .ad_data  (ad_data),
    .level    (level),
    .edge_sel (edge_sel),
    .crossing (crossing)
  );

  dso_sample_ram u_ram (
    .ad_clk (ad_clk),
    .wr_en  (wr_en),
    .wr_addr({wr_ptr[0], wr_addr}),
    .wr_data(ad_data),
    .rd_addr({rd_ptr[0], wave_rd_addr}),
    .rd_data(wave_rd_data)
  );

  // both banks held so the next record has not begun
  a_no_record_when_full: assert property (@(posedge ad_clk) disable iff (!rstn)
    full |-> ((data_cnt == '0) && !triggered));

  // at most two records outstanding
  a_rd_behind_wr: assert property (@(posedge ad_clk) disable iff (!rstn)
    bank_ptr_t'(wr_ptr - rd_ptr) <= 2'd2);

endmodule

`default_nettype wire

//--- dso_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "dso_consts.svh"

module dso_reg_decode (
  input  wire logic                           ad_clk,
  input  wire logic                           rstn,
  input  wire logic [`DSO_AXI_ADDR_WIDTH-1:0] s_awaddr,
  input  wire logic                           s_awvalid,
  output logic                                s_awready,
  input  wire logic [31:0]                    s_wdata,
  input  wire logic [3:0]                     s_wstrb,
  input  wire logic                           s_wvalid,
  output logic                                s_wready,
  output dso_pkg::axi_resp_t                  s_bresp,
  output logic                                s_bvalid,
  input  wire logic                           s_bready,
  input  wire logic [`DSO_AXI_ADDR_WIDTH-1:0] s_araddr,
  input  wire logic                           s_arvalid,
  output logic                                s_arready,
  input  wire logic                           rd_busy,
  input  wire logic                           wave_ready,
  input  wire logic [`DSO_ADDR_WIDTH-1:0]     wave_trig_addr,
  output logic                                run,
  output dso_pkg::edge_e                      edge_sel,
  output dso_pkg::sample_t                    level,
  output logic                                refresh_pulse,
  output logic                                rd_req,
  output logic                                rd_is_wave,
  output logic [31:0]                         rd_reg_data,
  output dso_pkg::axi_resp_t                  rd_resp,
  output logic [`DSO_ADDR_WIDTH-1:0]          wave_rd_addr
);
  import dso_pkg::*;

  reg_idx_e wr_idx, rd_idx;
  logic     wr_fire, ar_fire;

  function automatic reg_idx_e decode_addr(input logic [`DSO_AXI_ADDR_WIDTH-1:0] addr);
    reg_idx_e idx;
    if (addr >= `DSO_WAVE_BASE && addr < `DSO_WAVE_BASE + 4*`DSO_HORIZONTAL) begin
      idx = REG_WAVE;
    end else begin
      case (addr)
        `DSO_REG_CTRL:      idx = REG_CTRL;
        `DSO_REG_LEVEL:     idx = REG_LEVEL;
        `DSO_REG_STATUS:    idx = REG_STATUS;
        `DSO_REG_TRIG_ADDR: idx = REG_TRIG_ADDR;
        `DSO_REG_REFRESH:   idx = REG_REFRESH;
        default:            idx = REG_NONE;
      endcase
    end
    return idx;
  endfunction

  assign wr_idx  = decode_addr(s_awaddr);
  assign rd_idx  = decode_addr(s_araddr);
  assign wr_fire = s_awready && s_awvalid && s_wready && s_wvalid;
  assign ar_fire = s_arready && s_arvalid;

  // aw and w taken together, one outstanding response
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      s_awready <= 1'b0;
      s_wready  <= 1'b0;
      s_bvalid  <= 1'b0;
      s_bresp   <= RESP_OKAY;
    end else begin
      s_awready <= s_awvalid && s_wvalid && !s_bvalid && !s_awready;
      s_wready  <= s_awvalid && s_wvalid && !s_bvalid && !s_awready;
      if (wr_fire) begin
        s_bvalid <= 1'b1;
        s_bresp  <= (wr_idx == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
      end else if (s_bready) begin
        s_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      run      <= 1'b0;
      edge_sel <= EDGE_FALL;
      level    <= '0;
    end else if (wr_fire && s_wstrb[0]) begin
      if (wr_idx == REG_CTRL) begin
        run      <= s_wdata[0];
        edge_sel <= edge_e'(s_wdata[1]);
      end
      if (wr_idx == REG_LEVEL) begin
        level <= s_wdata[7:0];
      end
    end
  end

  assign refresh_pulse = wr_fire && (wr_idx == REG_REFRESH);  // data ignored

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      s_arready <= 1'b0;
    end else begin
      s_arready <= s_arvalid && !rd_busy && !s_arready;
    end
  end

  assign rd_req       = ar_fire;
  assign rd_is_wave   = (rd_idx == REG_WAVE);
  assign rd_resp      = (rd_idx == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
  assign wave_rd_addr = s_araddr[`DSO_ADDR_WIDTH+1:2];  // word index

  always_comb begin
    rd_reg_data = 32'h0;
    case (rd_idx)
      REG_CTRL:      rd_reg_data = {30'h0, edge_sel, run};
      REG_LEVEL:     rd_reg_data = {24'h0, level};
      REG_STATUS:    rd_reg_data = {31'h0, wave_ready};
      REG_TRIG_ADDR: rd_reg_data = {{(32-`DSO_ADDR_WIDTH){1'b0}}, wave_trig_addr};
      default:       rd_reg_data = 32'h0;
    endcase
  end

  a_bvalid_hold: assert property (@(posedge ad_clk) disable iff (!rstn)
    (s_bvalid && !s_bready) |=> (s_bvalid && $stable(s_bresp)));

endmodule

`default_nettype wire

//--- dso_readout.sv
`timescale 1ns/1ps
`default_nettype none

module dso_readout (
  input  wire logic               ad_clk,
  input  wire logic               rstn,
  input  wire logic               rd_req,
  input  wire logic               rd_is_wave,
  input  wire logic [31:0]        rd_reg_data,
  input  wire dso_pkg::axi_resp_t rd_resp,
  input  wire dso_pkg::sample_t   wave_rd_data,
  output logic                    rd_busy,
  output logic [31:0]             s_rdata,
  output dso_pkg::axi_resp_t      s_rresp,
  output logic                    s_rvalid,
  input  wire logic               s_rready
);
  import dso_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_VALID} rd_state_e;

  rd_state_e state;

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      state   <= RD_IDLE;
      s_rresp <= RESP_OKAY;
    end else begin
      case (state)
        RD_IDLE: if (rd_req) begin
          s_rresp <= rd_resp;
          state   <= rd_is_wave ? RD_WAIT : RD_VALID;
        end
        RD_WAIT:  state <= RD_VALID;  // ram output lands now
        RD_VALID: if (s_rready) state <= RD_IDLE;
        default:  state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge ad_clk) begin
    if (state == RD_IDLE && rd_req && !rd_is_wave) begin
      s_rdata <= rd_reg_data;
    end else if (state == RD_WAIT) begin
      s_rdata <= {24'h0, wave_rd_data};  // sample in low byte
    end
  end

  assign s_rvalid = (state == RD_VALID);
  assign rd_busy  = (state != RD_IDLE);

  // a request while busy would be lost
  a_req_when_idle: assert property (@(posedge ad_clk) disable iff (!rstn)
    rd_req |-> (state == RD_IDLE));

endmodule

`default_nettype wire

//--- dso_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dso_consts.svh"

module dso_top (
  input  wire logic                           ad_clk,
  input  wire logic                           rstn,
  input  wire dso_pkg::sample_t               ad_data,
  input  wire logic                           deci_valid,
  input  wire logic [`DSO_AXI_ADDR_WIDTH-1:0] s_awaddr,
  input  wire logic                           s_awvalid,
  output logic                                s_awready,
  input  wire logic [31:0]                    s_wdata,
  input  wire logic [3:0]                     s_wstrb,
  input  wire logic                           s_wvalid,
  output logic                                s_wready,
  output dso_pkg::axi_resp_t                  s_bresp,
  output logic                                s_bvalid,
  input  wire logic                           s_bready,
  input  wire logic [`DSO_AXI_ADDR_WIDTH-1:0] s_araddr,
  input  wire logic                           s_arvalid,
  output logic                                s_arready,
  output logic [31:0]                         s_rdata,
  output dso_pkg::axi_resp_t                  s_rresp,
  output logic                                s_rvalid,
  input  wire logic                           s_rready
);
  import dso_pkg::*;

  logic                       run, refresh_pulse;
  edge_e                      edge_sel;
  sample_t                    level, wave_rd_data;
  logic                       rd_busy, rd_req, rd_is_wave;
  logic [31:0]                rd_reg_data;
  axi_resp_t                  rd_resp;
  logic [`DSO_ADDR_WIDTH-1:0] wave_rd_addr, wave_trig_addr;
  logic                       wave_ready;

  dso_reg_decode u_decode (
    .ad_clk        (ad_clk),
    .rstn          (rstn),
    .s_awaddr      (s_awaddr),
    .s_awvalid     (s_awvalid),
    .s_awready     (s_awready),
    .s_wdata       (s_wdata),
    .s_wstrb       (s_wstrb),
    .s_wvalid      (s_wvalid),
    .s_wready      (s_wready),
    .s_bresp       (s_bresp),
    .s_bvalid      (s_bvalid),
    .s_bready      (s_bready),
    .s_araddr      (s_araddr),
    .s_arvalid     (s_arvalid),
    .s_arready     (s_arready),
    .rd_busy       (rd_busy),
    .wave_ready    (wave_ready),
    .wave_trig_addr(wave_trig_addr),
    .run           (run),
    .edge_sel      (edge_sel),
    .level         (level),
    .refresh_pulse (refresh_pulse),
    .rd_req        (rd_req),
    .rd_is_wave    (rd_is_wave),
    .rd_reg_data   (rd_reg_data),
    .rd_resp       (rd_resp),
    .wave_rd_addr  (wave_rd_addr)
  );

  dso_capture u_capture (
    .ad_clk        (ad_clk),
    .rstn          (rstn),
    .run           (run),
    .edge_sel      (edge_sel),
    .level         (level),
    .ad_data       (ad_data),
    .deci_valid    (deci_valid),
    .refresh_pulse (refresh_pulse),
    .wave_rd_addr  (wave_rd_addr),
    .wave_rd_data  (wave_rd_data),
    .wave_ready    (wave_ready),
    .wave_trig_addr(wave_trig_addr)
  );

  dso_readout u_readout (
    .ad_clk      (ad_clk),
    .rstn        (rstn),
    .rd_req      (rd_req),
    .rd_is_wave  (rd_is_wave),
    .rd_reg_data (rd_reg_data),
    .rd_resp     (rd_resp),
    .wave_rd_data(wave_rd_data),
    .rd_busy     (rd_busy),
    .s_rdata     (s_rdata),
    .s_rresp     (s_rresp),
    .s_rvalid    (s_rvalid),
    .s_rready    (s_rready)
  );

endmodule

`default_nettype wire

//--- tb_dso_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dso_consts.svh"

module tb_dso_top;
  import dso_pkg::*;

  localparam int H           = `DSO_HORIZONTAL;
  localparam int NUM_TESTS   = 6;
  localparam int MODEL_DEPTH = 16384;
  localparam int QUIET_POLLS = 200;
  localparam int TEST_CYCLES = 4 * (4 * H) + (3 * H) * 10;  // four records plus reads
  localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES + 2000;

  localparam logic [1:0] WAVE_UP   = 2'd0;
  localparam logic [1:0] WAVE_DOWN = 2'd1;
  localparam logic [1:0] WAVE_TRI  = 2'd2;
  localparam logic [1:0] WAVE_FLAT = 2'd3;

  typedef struct packed {
    edge_e      edge_sel;
    sample_t    level;
    logic [1:0] wave;
    logic       trig;  // record expected
  } entry_t;

  logic                           ad_clk, rstn, deci_valid;
  sample_t                        ad_data;
  logic [`DSO_AXI_ADDR_WIDTH-1:0] s_awaddr, s_araddr;
  logic                           s_awvalid, s_awready, s_wvalid, s_wready;
  logic                           s_bvalid, s_bready, s_arvalid, s_arready;
  logic                           s_rvalid, s_rready;
  logic [31:0]                    s_wdata, s_rdata;
  logic [3:0]                     s_wstrb;
  axi_resp_t                      s_bresp, s_rresp;

  entry_t     tests [NUM_TESTS];
  sample_t    model [MODEL_DEPTH];  // every strobed sample of the current test
  int         model_cnt, phase, cycles, checks, errors;
  logic [1:0] wave_kind;
  integer     seed;

  dso_top UUT (.*);

  initial ad_clk = 1'b0;
  always #20 ad_clk = ~ad_clk;

  function automatic sample_t wave_value(input logic [1:0] kind, input int step);
    int p;
    p = step % 256;
    case (kind)
      WAVE_UP:   wave_value = sample_t'(p);
      WAVE_DOWN: wave_value = sample_t'(255 - p);
      WAVE_TRI:  wave_value = (p < 128) ? sample_t'(2 * p) : sample_t'(2 * (255 - p));
      default:   wave_value = 8'h40;
    endcase
  endfunction

  // adc model, one waveform step per strobe
  always begin
    @(posedge ad_clk);
    #2;
    deci_valid = ({$random(seed)} % 4) != 0;
    ad_data    = wave_value(wave_kind, phase);
    if (deci_valid && model_cnt < MODEL_DEPTH) begin
      model[model_cnt] = ad_data;
      model_cnt        = model_cnt + 1;
    end
    if (deci_valid) phase = phase + 1;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge ad_clk);
      cycles = cycles + 1;
    end
    $display("timeout: run still busy after %0d clock cycles", CYCLE_LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check_sample(input string name, input sample_t exp, input sample_t got);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH at %0t ns: %s expected %02h got %02h", $time, name, exp, got);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t got);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH at %0t ns: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH at %0t ns: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH at %0t ns: %s expected %08h got %08h", $time, name, exp, got);
    end
  endtask

  task automatic axi_write(input logic [`DSO_AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           output axi_resp_t resp);
    int delay;
    @(posedge ad_clk);
    #2;
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    @(negedge ad_clk);
    while (!(s_awready && s_wready)) @(negedge ad_clk);
    delay = {$random(seed)} % 4;  // bready held back
    @(posedge ad_clk);
    #2;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    repeat (delay) begin
      @(posedge ad_clk);
      #2;
    end
    s_bready = 1'b1;
    @(negedge ad_clk);
    while (!s_bvalid) @(negedge ad_clk);
    resp = s_bresp;
    @(posedge ad_clk);
    #2;
    s_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`DSO_AXI_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                          output axi_resp_t resp);
    int delay;
    @(posedge ad_clk);
    #2;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    @(negedge ad_clk);
    while (!s_arready) @(negedge ad_clk);
    delay = {$random(seed)} % 4;  // rready back-pressure
    @(posedge ad_clk);
    #2;
    s_arvalid = 1'b0;
    repeat (delay) begin
      @(posedge ad_clk);
      #2;
    end
    s_rready = 1'b1;
    @(negedge ad_clk);
    while (!s_rvalid) @(negedge ad_clk);
    data = s_rdata;
    resp = s_rresp;
    @(posedge ad_clk);
    #2;
    s_rready = 1'b0;
  endtask

  task automatic write_ok(input logic [`DSO_AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    axi_resp_t resp;
    axi_write(addr, data, resp);
    check_resp("s_bresp", RESP_OKAY, resp);
  endtask

  task automatic read_word(input logic [`DSO_AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
                           input string name);
    logic [31:0] data;
    axi_resp_t   resp;
    axi_read(addr, data, resp);
    check_resp("s_rresp", RESP_OKAY, resp);
    check_word(name, exp, data);
  endtask

  task automatic wait_ready();
    logic [31:0] data;
    axi_resp_t   resp;
    data = '0;
    while (!data[0]) axi_read(`DSO_REG_STATUS, data, resp);
  endtask

  task automatic check_bank(input entry_t t);
    logic [31:0] data;
    axi_resp_t   resp;
    sample_t     bank [H];
    sample_t     s0, s1, s2, s3;
    logic        hit;
    int          trig, start, base, j, k;
    axi_read(`DSO_REG_TRIG_ADDR, data, resp);
    check_resp("s_rresp", RESP_OKAY, resp);
    trig = data[`DSO_ADDR_WIDTH-1:0];
    for (k = 0; k < H; k++) begin
      axi_read(`DSO_WAVE_BASE + 4 * k, data, resp);
      check_resp("s_rresp", RESP_OKAY, resp);
      bank[k] = data[7:0];
    end
    s0 = bank[trig];  // newest history sample
    s1 = bank[(trig + H - 1) % H];
    s2 = bank[(trig + H - 2) % H];
    s3 = bank[(trig + H - 3) % H];
    if (t.edge_sel == EDGE_RISE) begin
      hit = (s3 < t.level) && (s2 < t.level) && (s1 >= t.level) && (s0 > t.level);
    end else begin
      hit = (s3 > t.level) && (s2 > t.level) && (s1 <= t.level) && (s0 < t.level);
    end
    check_flag("crossing at trig_addr", 1'b1, hit);
    // trigger strobe lands at trig+1, with H/2-1 older samples kept ahead of it
    start = (trig + 1 + H - (H / 2 - 1)) % H;
    base  = -1;
    for (j = 0; j + H <= model_cnt && base < 0; j++) begin
      if (model[j] == bank[start] && model[j + 1] == bank[(start + 1) % H] &&
          model[j + 2] == bank[(start + 2) % H] && model[j + 3] == bank[(start + 3) % H]) begin
        base = j;
      end
    end
    if (base < 0) begin
      errors = errors + 1;
      $display("error at %0t ns: stored record is not a stretch of the sent samples", $time);
    end else begin
      for (k = 0; k < H; k++) begin
        check_sample($sformatf("wave[%0d]", (start + k) % H), model[base + k],
                     bank[(start + k) % H]);
      end
    end
  endtask

  task automatic run_entry(input int idx);
    entry_t t;
    int     start_err;
    t         = tests[idx];
    start_err = errors;
    write_ok(`DSO_REG_CTRL, 32'h0);  // stop clears both banks
    @(negedge ad_clk);
    wave_kind = t.wave;
    phase     = 0;
    model_cnt = 0;
    write_ok(`DSO_REG_LEVEL, {24'h0, t.level});
    write_ok(`DSO_REG_CTRL, {30'h0, t.edge_sel, 1'b1});
    if (t.trig) begin
      wait_ready();
      check_bank(t);
      // unreachable level so no third record completes
      write_ok(`DSO_REG_LEVEL, (t.edge_sel == EDGE_RISE) ? 32'hFF : 32'h00);
      write_ok(`DSO_REG_REFRESH, 32'h0);
      read_word(`DSO_REG_STATUS, 32'h1, "status after first refresh");
      check_bank(t);
      write_ok(`DSO_REG_REFRESH, 32'h0);
      read_word(`DSO_REG_STATUS, 32'h0, "status after second refresh");
      write_ok(`DSO_REG_LEVEL, {24'h0, t.level});
      wait_ready();
      write_ok(`DSO_REG_CTRL, 32'h0);
      read_word(`DSO_REG_STATUS, 32'h0, "status after run cleared");
    end else begin
      repeat (QUIET_POLLS) read_word(`DSO_REG_STATUS, 32'h0, "status without trigger");
    end
    $display("test %0d edge %0d level %02h wave %0d: %0d errors", idx, t.edge_sel, t.level,
             t.wave, errors - start_err);
  endtask

  initial begin : main_seq
    axi_resp_t resp;
    logic [31:0] data;
    int          i;
    seed       = 81742;
    checks     = 0;
    errors     = 0;
    model_cnt  = 0;
    phase      = 0;
    wave_kind  = WAVE_FLAT;
    rstn       = 1'b0;
    ad_data    = '0;
    deci_valid = 1'b0;
    s_awaddr   = '0;
    s_awvalid  = 1'b0;
    s_wdata    = '0;
    s_wstrb    = 4'hF;
    s_wvalid   = 1'b0;
    s_bready   = 1'b0;
    s_araddr   = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    tests[0] = '{EDGE_RISE, 8'h80, WAVE_UP,   1'b1};
    tests[1] = '{EDGE_FALL, 8'h60, WAVE_DOWN, 1'b1};
    tests[2] = '{EDGE_RISE, 8'h81, WAVE_TRI,  1'b1};
    tests[3] = '{EDGE_FALL, 8'h40, WAVE_TRI,  1'b1};
    tests[4] = '{EDGE_RISE, 8'h40, WAVE_FLAT, 1'b0};
    tests[5] = '{EDGE_RISE, 8'hFF, WAVE_UP,   1'b0};  // h0 can never exceed full scale
    repeat (3) @(posedge ad_clk);
    #2;
    rstn = 1'b1;
    @(negedge ad_clk);
    check_flag("s_awready", 1'b0, s_awready);
    check_flag("s_wready", 1'b0, s_wready);
    check_flag("s_arready", 1'b0, s_arready);
    check_flag("s_bvalid", 1'b0, s_bvalid);
    check_flag("s_rvalid", 1'b0, s_rvalid);
    read_word(`DSO_REG_STATUS, 32'h0, "status after reset");
    read_word(`DSO_REG_TRIG_ADDR, 32'h0, "trig_addr after reset");
    read_word(`DSO_REG_CTRL, 32'h0, "ctrl after reset");
    axi_write(13'h0014, 32'h1, resp);
    check_resp("s_bresp unknown offset", RESP_SLVERR, resp);
    axi_read(13'h0014, data, resp);
    check_resp("s_rresp unknown offset", RESP_SLVERR, resp);
    $display("test reset: %0d errors", errors);
    for (i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end
    $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
dso_pkg.sv
dso_trigger.sv
dso_sample_ram.sv
dso_capture.sv
dso_reg_decode.sv
dso_readout.sv
dso_top.sv
tb_dso_top.sv

//--- Bender.yml
package:
  name: dso_capture

export_include_dirs:
  - .

sources:
  - dso_pkg.sv
  - dso_trigger.sv
  - dso_sample_ram.sv
  - dso_capture.sv
  - dso_reg_decode.sv
  - dso_readout.sv
  - dso_top.sv
  - target: simulation
    files:
      - tb_dso_top.sv
